//--- files.f
+incdir+.
spi_pkg.sv
spi_bus_if.sv
afifo_gray.sv
spi_layer.sv
spi_reg_target.sv
spi_top.sv
tb_spi_top.sv

//--- run.sh
#!/bin/sh
# Build and run the SPI slave bridge testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_spi_top -f files.f

# The run passes only when the testbench reports success.
if ./obj_dir/Vtb_spi_top | tee /dev/stderr | grep -q "Simulation PASSED"; then
   echo "run.sh: testbench passed"
else
   echo "run.sh: testbench failed"
   exit 1
fi

//--- tb_spi_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_macros.svh"

module tb_spi_top
   import spi_pkg::*;
();

   // SCK half period of 40 ns in clk_i cycles.
   localparam int SCK_HALF = 5;
   // Longest bus-side wait in clk_i cycles.
   localparam int WAIT_MAX = 40;

   logic clk_i;
   logic SSEL;
   logic sck_i;
   logic spi_cs_n_i;
   logic mosi_i;
   logic miso_o;
   logic overflow_o;
   logic underrun_o;

   // Flag monitor is armed once reset is released.
   logic running;

   // Reference register file and running write count.
   byte_t model_regs [1 << `SPI_ADDR_BITS];
   byte_t model_count;

   // Bytes sent, received and expected in one frame.
   byte_t mosi_q [$];
   byte_t miso_q [$];
   byte_t exp_q  [$];

   spi_top DUT (
      .clk_i      (clk_i),
      .SSEL       (SSEL),
      .sck_i      (sck_i),
      .spi_cs_n_i (spi_cs_n_i),
      .mosi_i     (mosi_i),
      .miso_o     (miso_o),
      .overflow_o (overflow_o),
      .underrun_o (underrun_o)
   );

   // 8 ns bus clock.
   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   // ------------------------------------------------------------------
   // Error handling and compare tasks.
   // ------------------------------------------------------------------
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_byte(input byte_t got, input byte_t exp, input string what);
      if (got !== exp) begin
         abort_run($sformatf("Fail at %0t ns: %s is %02h, expected %02h",
                             $time, what, got, exp));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         abort_run($sformatf("Fail at %0t ns: %s is %b, expected %b",
                             $time, what, got, exp));
      end
   endtask

   // Sticky error flags must never rise.
   always @(posedge clk_i) begin
      if (running) begin
         check_flag(overflow_o, 1'b0, "overflow_o");
         check_flag(underrun_o, 1'b0, "underrun_o");
      end
   end

   // ------------------------------------------------------------------
   // Reference model.
   // ------------------------------------------------------------------
   // Expected MISO byte at position idx of a frame opened by cmd.
   function automatic byte_t expected_miso(input byte_t cmd, input int idx);
      reg_addr_t addr;
      addr = reg_addr_t'(cmd[`SPI_ADDR_BITS-1:0] + idx - 2);
      if (idx == 0) return `SPI_HEADER_BYTE;
      // Count of writes from all earlier frames.
      if (idx == 1) return model_count;
      if (cmd[7]) return model_regs[addr];
      return '0;
   endfunction

   // Apply the complete bytes of a finished frame to the model.
   function automatic void model_commit(input int n_full);
      reg_addr_t addr;
      byte_t     cmd;
      cmd  = mosi_q[0];
      addr = reg_addr_t'(cmd);
      if (!cmd[7]) begin
         for (int i = 1; i < n_full; i++) begin
            model_regs[addr] = mosi_q[i];
            addr             = addr + reg_addr_t'(1);
            model_count      = model_count + 8'd1;
         end
      end
   endfunction

   // ------------------------------------------------------------------
   // Timing helpers and SPI master.
   // ------------------------------------------------------------------
   // Inputs change 1 ns after the rising clk_i edge.
   task automatic clk_step(input int n);
      repeat (n) @(posedge clk_i);
      #1;
   endtask

   // Synchronised chip select reaching the given level.
   task automatic wait_cyc(input logic level);
      int n;
      n = 0;
      while (DUT.bus_if.cyc !== level) begin
         if (n == WAIT_MAX) begin
            abort_run("Timeout: chip select did not reach the bus side");
         end
         clk_step(1);
         n++;
      end
   endtask

   // Target has drained every received byte.
   task automatic wait_rx_drained();
      int n;
      n = 0;
      while (DUT.bus_if.wat !== 1'b1) begin
         if (n == WAIT_MAX) begin
            abort_run("Timeout: received bytes were not drained by the target");
         end
         clk_step(1);
         n++;
      end
   endtask

   // SCK idles low. MOSI changes after the fall and MISO is taken at the rise.
   task automatic shift_bits(input byte_t val, input int nbits, output byte_t got);
      got = '0;
      for (int i = 0; i < nbits; i++) begin
         mosi_i = val[7-i];
         clk_step(SCK_HALF);
         got   = {got[6:0], miso_o};
         sck_i = 1'b1;
         clk_step(SCK_HALF);
         sck_i = 1'b0;
      end
   endtask

   // Full frame from mosi_q that may end inside one more byte.
   task automatic spi_transfer(input int extra_bits);
      byte_t got;
      miso_q.delete();
      spi_cs_n_i = 1'b0;
      wait_cyc(1'b1);
      foreach (mosi_q[i]) begin
         shift_bits(mosi_q[i], 8, got);
         miso_q.push_back(got);
      end
      // A partial byte never reaches the RX FIFO.
      if (extra_bits > 0) begin
         shift_bits(byte_t'($urandom), extra_bits, got);
      end
      wait_rx_drained();
      spi_cs_n_i = 1'b1;
      wait_cyc(1'b0);
      // Room for the TX FIFO clear.
      clk_step(4);
   endtask

   // Command byte plus len random bytes.
   // The frame is then compared and committed.
   task automatic run_case(input logic is_read, input reg_addr_t addr, input int len,
                           input int extra_bits, input string name);
      byte_t cmd;
      cmd    = byte_t'(addr);
      cmd[7] = is_read;
      mosi_q.delete();
      exp_q.delete();
      mosi_q.push_back(cmd);
      for (int i = 0; i < len; i++) begin
         mosi_q.push_back(byte_t'($urandom));
      end
      // Expected bytes use the model as it was before this frame.
      foreach (mosi_q[i]) begin
         exp_q.push_back(expected_miso(cmd, i));
      end
      spi_transfer(extra_bits);
      foreach (miso_q[i]) begin
         check_byte(miso_q[i], exp_q[i], $sformatf("%s, MISO byte %0d", name, i));
      end
      check_flag(overflow_o, 1'b0, "overflow_o");
      check_flag(underrun_o, 1'b0, "underrun_o");
      model_commit(mosi_q.size());
   endtask

   // ------------------------------------------------------------------
   // Test sequence.
   // ------------------------------------------------------------------
   initial begin
      reg_addr_t addr;
      int        len;
      void'($urandom(32'h9ff3_7621));
      running     = 1'b0;
      model_count = '0;
      SSEL        = 1'b1;
      sck_i       = 1'b0;
      spi_cs_n_i  = 1'b1;
      mosi_i      = 1'b0;
      for (int i = 0; i < (1 << `SPI_ADDR_BITS); i++) begin
         model_regs[i] = '0;
      end

      // Reset held for 4 clk_i cycles.
      clk_step(4);
      SSEL    = 1'b0;
      running = 1'b1;
      clk_step(4);

      // Fill every register and read all of them back.
      run_case(1'b0, 4'd0, 16, 0, "fill");
      run_case(1'b1, 4'd0, 17, 0, "readback");

      // Random spans of which some run past address 15.
      for (int t = 0; t < 8; t++) begin
         addr = reg_addr_t'($urandom);
         len  = 1 + int'($urandom % 9);
         run_case(1'b0, addr, len, 0, "write");
         run_case(1'b1, addr, len + 1, 0, "read");
      end

      // Forced wrap from 14 through 2.
      run_case(1'b0, 4'd14, 5, 0, "wrap write");
      run_case(1'b1, 4'd14, 6, 0, "wrap read");

      // Two bytes land and the third is cut after 3 bits.
      run_case(1'b0, 4'd3, 2, 3, "aborted write");
      run_case(1'b1, 4'd3, 4, 0, "read after abort");

      // A read cut short changes nothing.
      run_case(1'b1, 4'd9, 3, 5, "aborted read");
      run_case(1'b1, 4'd0, 17, 0, "full read");

      // A long stream makes the write count wrap past 255.
      run_case(1'b0, reg_addr_t'($urandom), 240, 0, "stream write");
      run_case(1'b1, 4'd0, 17, 0, "final read");

      clk_step(8);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- spi_top.sv
`timescale 1ns/1ns
`default_nettype none

// ---------------------------------------------------------------------
// SPI slave bridge into a small register file.
// ---------------------------------------------------------------------
module spi_top (
   input  logic clk_i,
   input  logic SSEL,
   input  logic sck_i,
   input  logic spi_cs_n_i,
   input  logic mosi_i,
   output logic miso_o,
   output logic overflow_o,
   output logic underrun_o
);

   // Bus-side link between the SPI layer and the target.
   spi_bus_if bus_if ();

   // SCK domain, synchronisers and both FIFOs.
   spi_layer u_layer (
      .clk_i      (clk_i),
      .SSEL       (SSEL),
      .sck_i      (sck_i),
      .spi_cs_n_i (spi_cs_n_i),
      .mosi_i     (mosi_i),
      .miso_o     (miso_o),
      .overflow_o (overflow_o),
      .underrun_o (underrun_o),
      .bus        (bus_if.layer)
   );

   // Command decode and register file in clk_i.
   spi_reg_target u_target (
      .clk_i (clk_i),
      .SSEL  (SSEL),
      .bus   (bus_if.target)
   );

endmodule

`default_nettype wire

//--- spi_reg_target.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_macros.svh"

module spi_reg_target
   import spi_pkg::*;
(
   input  logic      clk_i,
   input  logic      SSEL,
   spi_bus_if.target bus
);

   tgt_state_e state;
   reg_addr_t  ptr;
   byte_t      wr_count;
   logic       rdy_q;
   byte_t      tx_q;
   logic       tx_take;
   logic       wr_hit;

   // 16-byte register file.
   byte_t      regs [1 << `SPI_ADDR_BITS];

   // Drain every received byte as soon as it shows up.
   assign bus.ack    = bus.cyc && !bus.wat;
   assign bus.rdy    = rdy_q;
   assign bus.dat_tx = tx_q;

   // Answer a prefetch once, and only inside the frame.
   assign tx_take = bus.get && bus.cyc && !rdy_q;
   assign wr_hit  = bus.ack && (state == WRITE);

   // ------------------------------------------------------------------
   // Command FSM and pointers.
   // ------------------------------------------------------------------
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         state    <= IDLE;
         ptr      <= '0;
         wr_count <= '0;
         rdy_q    <= 1'b0;
      end else begin
         rdy_q <= tx_take;
         if (!bus.cyc) begin
            state <= IDLE;
         end else begin
            case (state)
               IDLE: begin
                  state <= CMD;
               end
               CMD: begin
                  // Bit 7 picks the direction, low bits the start address.
                  if (bus.ack) begin
                     state <= bus.dat_rx[7] ? READ : WRITE;
                     ptr   <= bus.dat_rx[`SPI_ADDR_BITS-1:0];
                  end
               end
               WRITE: begin
                  if (wr_hit) begin
                     ptr      <= ptr + reg_addr_t'(1);
                     wr_count <= wr_count + 8'd1;
                  end
               end
               READ: begin
                  if (tx_take) begin
                     ptr <= ptr + reg_addr_t'(1);
                  end
               end
               default: begin
                  state <= IDLE;
               end
            endcase
         end
      end
   end

   // ------------------------------------------------------------------
   // Register file and prefetch answer.
   // ------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (wr_hit) begin
         regs[ptr] <= bus.dat_rx;
      end
   end

   // Write count until the command lands, then read data or zero.
   always_ff @(posedge clk_i) begin
      if (tx_take) begin
         case (state)
            READ:    tx_q <= regs[ptr];
            WRITE:   tx_q <= '0;
            default: tx_q <= wr_count;
         endcase
      end
   end

   // Each rdy answers a pending get, and the layer then drops get.
   a_rdy_after_get: assert property (@(posedge clk_i) disable iff (SSEL)
      bus.rdy |-> $past(bus.get) ##1 !bus.get);

endmodule

`default_nettype wire

//--- spi_layer.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_macros.svh"

module spi_layer
   import spi_pkg::*;
(
   input  logic     clk_i,
   input  logic     SSEL,
   input  logic     sck_i,
   input  logic     spi_cs_n_i,
   input  logic     mosi_i,
   output logic     miso_o,
   output logic     overflow_o,
   output logic     underrun_o,
   spi_bus_if.layer bus
);

   localparam byte_t HEADER = `SPI_HEADER_BYTE;

   // SCK-domain state is held clear while deselected or in reset.
   logic       sck_clr;
   // Transmit data leaves on falling SCK.
   logic       sck_tx;

   logic [6:0] rx_reg;
   logic [2:0] rx_count;
   logic       rx_push, rx_full, rx_empty;
   byte_t      rx_data;

   logic [6:0] tx_reg;
   logic [2:0] tx_count;
   logic       tx_next, tx_pull, tx_empty;
   byte_t      tx_data;

   logic       cs_meta, cyc_q;
   logic       spi_req, req_meta, req_sync, req_done, get_q;
   logic       tx_rst, tx_flg;

   assign sck_clr = spi_cs_n_i | SSEL;
   assign sck_tx  = ~sck_i;

   assign bus.cyc = cyc_q;
   assign bus.get = get_q;
   assign bus.wat = rx_empty;

   // ------------------------------------------------------------------
   // Receive, MSB first on rising SCK.
   // ------------------------------------------------------------------
   assign rx_push = (rx_count == 3'd7);
   // Last bit is taken straight off the pin.
   assign rx_data = {rx_reg, mosi_i};

   always_ff @(posedge sck_i) begin
      rx_reg <= {rx_reg[5:0], mosi_i};
   end

   // Bit counter, plus a prefetch request on the first bit of a byte.
   always_ff @(posedge sck_i or posedge sck_clr) begin
      if (sck_clr) begin
         rx_count <= '0;
         spi_req  <= 1'b0;
      end else begin
         rx_count <= rx_count + 3'd1;
         spi_req  <= (rx_count == 3'd0);
      end
   end

   // Sticky, a byte was dropped into a full RX FIFO.
   always_ff @(posedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         overflow_o <= 1'b0;
      end else if (rx_push && rx_full) begin
         overflow_o <= 1'b1;
      end
   end

   // ------------------------------------------------------------------
   // Transmit, MSB first on falling SCK.
   // ------------------------------------------------------------------
   assign tx_next = (tx_count == 3'd7);

   // Header bit sits on MISO before the first rising edge.
   // Next byte is loaded on the 8th falling edge, the FIFO pops one edge later.
   always_ff @(negedge sck_i or posedge sck_clr) begin
      if (sck_clr) begin
         tx_count <= '0;
         tx_pull  <= 1'b0;
         tx_reg   <= HEADER[6:0];
         miso_o   <= HEADER[7];
      end else begin
         tx_count <= tx_count + 3'd1;
         tx_pull  <= tx_next;
         if (tx_next) begin
            tx_reg <= tx_data[6:0];
            miso_o <= tx_data[7];
         end else begin
            tx_reg <= {tx_reg[5:0], 1'b0};
            miso_o <= tx_reg[6];
         end
      end
   end

   // Sticky, the bus side was late with a byte.
   always_ff @(negedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         underrun_o <= 1'b0;
      end else if (tx_pull && tx_empty) begin
         underrun_o <= 1'b1;
      end
   end

   // ------------------------------------------------------------------
   // Crossings into clk_i.
   // ------------------------------------------------------------------
   // Chip select, two flops.
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         cs_meta <= 1'b0;
         cyc_q   <= 1'b0;
      end else begin
         cs_meta <= ~spi_cs_n_i;
         cyc_q   <= cs_meta;
      end
   end

   // Prefetch one-shot.
   // get drops after rdy, and stays blocked until the request falls.
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         req_meta <= 1'b0;
         req_sync <= 1'b0;
         req_done <= 1'b0;
         get_q    <= 1'b0;
      end else begin
         req_meta <= spi_req;
         req_sync <= req_meta;
         req_done <= req_done ? req_sync : (get_q && bus.rdy);
         get_q    <= req_sync && !req_done && !bus.rdy;
      end
   end

   // One TX FIFO clear per deselect, drops stale prefetched bytes.
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         tx_rst <= 1'b1;
         tx_flg <= 1'b0;
      end else if (cyc_q) begin
         tx_rst <= 1'b0;
         tx_flg <= 1'b0;
      end else begin
         tx_rst <= ~tx_flg;
         tx_flg <= 1'b1;
      end
   end

   // ------------------------------------------------------------------
   // Clock-crossing FIFOs.
   // ------------------------------------------------------------------
   afifo_gray TX_FIFO0 (
      .rd_clk_i  (sck_tx),
      .rd_en_i   (tx_pull),
      .rd_data_o (tx_data),
      .rempty_o  (tx_empty),
      .wr_clk_i  (clk_i),
      .wr_en_i   (bus.rdy),
      .wr_data_i (bus.dat_tx),
      .wfull_o   (),
      .rst_i     (tx_rst)
   );

   afifo_gray RX_FIFO0 (
      .rd_clk_i  (clk_i),
      .rd_en_i   (bus.ack),
      .rd_data_o (bus.dat_rx),
      .rempty_o  (rx_empty),
      .wr_clk_i  (sck_i),
      .wr_en_i   (rx_push),
      .wr_data_i (rx_data),
      .wfull_o   (rx_full),
      .rst_i     (SSEL)
   );

   // SCK activity must only reach the bus inside a selected frame.
   a_get_inside_cyc: assert property (@(posedge clk_i) disable iff (SSEL)
      $rose(get_q) |-> cyc_q);

endmodule

`default_nettype wire

//--- afifo_gray.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_macros.svh"

module afifo_gray
   import spi_pkg::*;
#(
   parameter int WIDTH = `SPI_DATA_BITS,
   parameter int ABITS = `SPI_FIFO_ABITS
) (
   input  logic  rd_clk_i,
   input  logic  rd_en_i,
   output byte_t rd_data_o,
   output logic  rempty_o,
   input  logic  wr_clk_i,
   input  logic  wr_en_i,
   input  byte_t wr_data_i,
   output logic  wfull_o,
   input  logic  rst_i
);

   localparam int DEPTH = 1 << ABITS;

   // Storage, written in the write domain and read as first-word fall-through.
   logic [WIDTH-1:0] mem [DEPTH];

   logic [ABITS:0]   wbin, wgray, wbin_nxt, wgray_nxt;
   logic [ABITS:0]   rbin, rgray, rbin_nxt, rgray_nxt;
   logic [ABITS:0]   wq1_rgray, wq2_rgray;
   logic [ABITS:0]   rq1_wgray, rq2_wgray;
   logic             wr_ok, rd_ok;

   // The memory and the ports share one width.
   if (WIDTH != $bits(byte_t)) begin : g_width_check
      $error("afifo_gray WIDTH differs from byte_t");
   end

   // ------------------------------------------------------------------
   // Write domain.
   // ------------------------------------------------------------------
   assign wr_ok     = wr_en_i && !wfull_o;
   assign wbin_nxt  = wbin + {{ABITS{1'b0}}, wr_ok};
   assign wgray_nxt = wbin_nxt ^ (wbin_nxt >> 1);

   // Full when the synced read pointer is one lap behind.
   // The top two gray bits differ, the rest match.
   assign wfull_o = (wgray == {~wq2_rgray[ABITS:ABITS-1], wq2_rgray[ABITS-2:0]});

   always_ff @(posedge wr_clk_i or posedge rst_i) begin
      if (rst_i) begin
         wbin  <= '0;
         wgray <= '0;
      end else begin
         wbin  <= wbin_nxt;
         wgray <= wgray_nxt;
      end
   end

   always_ff @(posedge wr_clk_i) begin
      if (wr_ok) begin
         mem[wbin[ABITS-1:0]] <= wr_data_i[WIDTH-1:0];
      end
   end

   // Two-stage synchroniser for the read pointer.
   always_ff @(posedge wr_clk_i or posedge rst_i) begin
      if (rst_i) begin
         wq1_rgray <= '0;
         wq2_rgray <= '0;
      end else begin
         wq1_rgray <= rgray;
         wq2_rgray <= wq1_rgray;
      end
   end

   // ------------------------------------------------------------------
   // Read domain.
   // ------------------------------------------------------------------
   assign rd_ok     = rd_en_i && !rempty_o;
   assign rbin_nxt  = rbin + {{ABITS{1'b0}}, rd_ok};
   assign rgray_nxt = rbin_nxt ^ (rbin_nxt >> 1);

   // Empty once the read pointer catches the synced write pointer.
   assign rempty_o  = (rgray == rq2_wgray);
   assign rd_data_o = mem[rbin[ABITS-1:0]];

   always_ff @(posedge rd_clk_i or posedge rst_i) begin
      if (rst_i) begin
         rbin  <= '0;
         rgray <= '0;
      end else begin
         rbin  <= rbin_nxt;
         rgray <= rgray_nxt;
      end
   end

   // Two-stage synchroniser for the write pointer.
   always_ff @(posedge rd_clk_i or posedge rst_i) begin
      if (rst_i) begin
         rq1_wgray <= '0;
         rq2_wgray <= '0;
      end else begin
         rq1_wgray <= wgray;
         rq2_wgray <= rq1_wgray;
      end
   end

   // The producer must pace itself against the far side's drain.
   a_no_write_full: assert property (@(posedge wr_clk_i) disable iff (rst_i)
      wr_en_i |-> !wfull_o);

   // The consumer must wait for data to cross over.
   a_no_read_empty: assert property (@(posedge rd_clk_i) disable iff (rst_i)
      rd_en_i |-> !rempty_o);

endmodule

`default_nettype wire

//--- spi_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

// ---------------------------------------------------------------------
// Bus-side link between the SPI layer and the register target.
// ---------------------------------------------------------------------
interface spi_bus_if
   import spi_pkg::*;
   ();

   // Synchronised chip select, frames one bus transaction.
   logic  cyc;
   // Prefetch request, held until rdy.
   logic  get;
   // RX FIFO empty.
   logic  wat;
   // Head of the RX FIFO.
   byte_t dat_rx;

   // One-cycle push of dat_tx into the TX FIFO.
   logic  rdy;
   // One-cycle pop of the RX FIFO.
   logic  ack;
   // Byte for the next MISO slot.
   byte_t dat_tx;

   // SPI side owns framing and the RX data path.
   modport layer (
      output cyc, get, wat, dat_rx,
      input  rdy, ack, dat_tx
   );

   // Target answers prefetches and drains received bytes.
   modport target (
      input  cyc, get, wat, dat_rx,
      output rdy, ack, dat_tx
   );

endinterface

`default_nettype wire

//--- spi_pkg.sv
`default_nettype none

`include "spi_macros.svh"

// ---------------------------------------------------------------------
// Types shared by the SPI slave bridge.
// ---------------------------------------------------------------------
package spi_pkg;

   // One byte of SPI payload.
   typedef logic [`SPI_DATA_BITS-1:0] byte_t;

   // FIFO pointer, binary or gray, with the wrap bit on top.
   typedef logic [`SPI_FIFO_ABITS:0] fifo_ptr_t;

   // Register file address.
   typedef logic [`SPI_ADDR_BITS-1:0] reg_addr_t;

   // Register target states.
   // IDLE waits for select, CMD waits for the command byte.
   typedef enum logic [1:0] {
      IDLE,
      CMD,
      WRITE,
      READ
   } tgt_state_e;

endpackage

`default_nettype wire

//--- spi_macros.svh
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// ---------------------------------------------------------------------
// SPI slave bridge build constants.
// ---------------------------------------------------------------------

// First byte shifted out on MISO in every transaction.
`define SPI_HEADER_BYTE 8'hA7

// Width of one data byte in the bridge.
`define SPI_DATA_BITS 8

// Log2 of the clock-crossing FIFO depth.
// Pointers carry one extra wrap bit.
`define SPI_FIFO_ABITS 2

// Register file address width, 16 bytes.
`define SPI_ADDR_BITS 4

`endif
